// File: src/rv_decode_pkg.sv
// RISC-V decode definitions
`default_nettype none

package rv_decode_pkg;

    // =========================================================================
    // Widths
    // =========================================================================
    localparam int XLEN       = 32;  // Instruction word and immediate width
    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // =========================================================================
    // Operations
    // =========================================================================
    typedef enum logic [5:0] {
        OP_NONE = 6'd0,  // Illegal encoding, matches the reset record
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_FENCE
    } op_type_e;

    // =========================================================================
    // Encodings
    // =========================================================================
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;  // FENCE only

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    // =========================================================================
    // Records
    // =========================================================================
    typedef struct packed {
        op_type_e        op;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [XLEN-1:0] imm;
        logic            load_rs;  // rs1 or rs2 read from the register file
    } decoded_instr_t;

    // All immediate formats of one word
    typedef struct packed {
        logic [XLEN-1:0] i_imm;
        logic [XLEN-1:0] s_imm;
        logic [XLEN-1:0] b_imm;
        logic [XLEN-1:0] u_imm;
        logic [XLEN-1:0] j_imm;
    } imm_set_t;

endpackage

`default_nettype wire

// File: src/rv_imm_gen.sv
// RV32I immediate generator
`default_nettype none

module rv_imm_gen (
    input  wire [rv_decode_pkg::XLEN-1:0] instr_i,
    output rv_decode_pkg::imm_set_t       imm_o
);

    logic sign;

    assign sign = instr_i[31];  // Every format takes its sign from bit 31

    assign imm_o.i_imm = {{20{sign}}, instr_i[31:20]};
    assign imm_o.s_imm = {{20{sign}}, instr_i[31:25], instr_i[11:7]};

    // Branch offset, bit 0 always zero
    assign imm_o.b_imm = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                          instr_i[11:8], 1'b0};

    assign imm_o.u_imm = {instr_i[31:12], 12'b0};

    // Jump offset, same layout idea as the branch but 20 bits
    assign imm_o.j_imm = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                          instr_i[30:21], 1'b0};

endmodule

`default_nettype wire

// File: src/rv32i_decoder.sv
// RV32I base decoder
`default_nettype none

module rv32i_decoder (
    input  wire [rv_decode_pkg::XLEN-1:0] instr_i,
    output rv_decode_pkg::decoded_instr_t instr_o,
    output logic                          illegal_o
);

    import rv_decode_pkg::*;

    imm_set_t   imm_set;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    rv_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .imm_o   (imm_set)
    );

    // =========================================================================
    // Opcode dispatch
    // =========================================================================
    always_comb begin
        instr_o   = '0;  // Unused fields stay zero
        illegal_o = 1'b0;
        case (opcode)
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  instr_o.op = OP_BEQ;
                    3'b001:  instr_o.op = OP_BNE;
                    3'b100:  instr_o.op = OP_BLT;
                    3'b101:  instr_o.op = OP_BGE;
                    3'b110:  instr_o.op = OP_BLTU;
                    3'b111:  instr_o.op = OP_BGEU;
                    default: illegal_o = 1'b1;
                endcase
                instr_o.rs1     = instr_i[19:15];
                instr_o.rs2     = instr_i[24:20];
                instr_o.imm     = imm_set.b_imm;
                instr_o.load_rs = 1'b1;
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  instr_o.op = OP_LB;
                    3'b001:  instr_o.op = OP_LH;
                    3'b010:  instr_o.op = OP_LW;
                    3'b100:  instr_o.op = OP_LBU;
                    3'b101:  instr_o.op = OP_LHU;
                    default: illegal_o = 1'b1;
                endcase
                instr_o.rd      = instr_i[11:7];
                instr_o.rs1     = instr_i[19:15];
                instr_o.imm     = imm_set.i_imm;
                instr_o.load_rs = 1'b1;
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  instr_o.op = OP_SB;
                    3'b001:  instr_o.op = OP_SH;
                    3'b010:  instr_o.op = OP_SW;
                    default: illegal_o = 1'b1;
                endcase
                instr_o.rs1     = instr_i[19:15];
                instr_o.rs2     = instr_i[24:20];
                instr_o.imm     = imm_set.s_imm;
                instr_o.load_rs = 1'b1;
            end
            OPC_OP_IMM: begin
                instr_o.rd      = instr_i[11:7];
                instr_o.rs1     = instr_i[19:15];
                instr_o.imm     = imm_set.i_imm;
                instr_o.load_rs = 1'b1;
                case (funct3)
                    3'b000: instr_o.op = OP_ADDI;
                    3'b010: instr_o.op = OP_SLTI;
                    3'b011: instr_o.op = OP_SLTIU;
                    3'b100: instr_o.op = OP_XORI;
                    3'b110: instr_o.op = OP_ORI;
                    3'b111: instr_o.op = OP_ANDI;
                    default: begin  // Shifts carry only the shamt
                        instr_o.imm = {27'b0, instr_i[24:20]};
                        if (funct3 == 3'b001 && funct7 == F7_BASE) begin
                            instr_o.op = OP_SLLI;
                        end else if (funct3 == 3'b101 && funct7 == F7_BASE) begin
                            instr_o.op = OP_SRLI;
                        end else if (funct3 == 3'b101 && funct7 == F7_ALT) begin
                            instr_o.op = OP_SRAI;
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: instr_o.op = OP_ADD;
                    {F7_ALT,  3'b000}: instr_o.op = OP_SUB;
                    {F7_BASE, 3'b001}: instr_o.op = OP_SLL;
                    {F7_BASE, 3'b010}: instr_o.op = OP_SLT;
                    {F7_BASE, 3'b011}: instr_o.op = OP_SLTU;
                    {F7_BASE, 3'b100}: instr_o.op = OP_XOR;
                    {F7_BASE, 3'b101}: instr_o.op = OP_SRL;
                    {F7_ALT,  3'b101}: instr_o.op = OP_SRA;
                    {F7_BASE, 3'b110}: instr_o.op = OP_OR;
                    {F7_BASE, 3'b111}: instr_o.op = OP_AND;
                    default:           illegal_o = 1'b1;  // M extension lands here
                endcase
                instr_o.rd      = instr_i[11:7];
                instr_o.rs1     = instr_i[19:15];
                instr_o.rs2     = instr_i[24:20];
                instr_o.load_rs = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                instr_o.op  = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
                instr_o.rd  = instr_i[11:7];
                instr_o.imm = imm_set.u_imm;
            end
            OPC_JAL: begin
                instr_o.op  = OP_JAL;
                instr_o.rd  = instr_i[11:7];
                instr_o.imm = imm_set.j_imm;
            end
            OPC_JALR, OPC_MISC_MEM: begin
                instr_o.op      = (opcode == OPC_JALR) ? OP_JALR : OP_FENCE;
                illegal_o       = (funct3 != 3'b000);  // FENCE.I is not kept
                instr_o.rd      = instr_i[11:7];
                instr_o.rs1     = instr_i[19:15];
                instr_o.imm     = imm_set.i_imm;
                instr_o.load_rs = 1'b1;
            end
            default: illegal_o = 1'b1;  // SYSTEM, AMO and unknown opcodes
        endcase

        if (illegal_o) begin
            instr_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: src/rvc_decoder.sv
// RV32C compressed instruction expander
`default_nettype none

module rvc_decoder #(
    parameter bit ENABLE_RVC = 1'b1
) (
    input  wire [rv_decode_pkg::XLEN-1:0]      instr_i,
    input  wire rv_decode_pkg::decoded_instr_t base_instr_i,
    input  wire                                base_illegal_i,
    output rv_decode_pkg::decoded_instr_t      instr_o,
    output logic                               illegal_o
);

    import rv_decode_pkg::*;

    localparam reg_idx_t REG_RA = 5'd1;
    localparam reg_idx_t REG_SP = 5'd2;

    logic [15:0]    c;
    logic           is_rvc;
    reg_idx_t       rs1_p;    // Popular register from [9:7]
    reg_idx_t       rs2_p;    // Popular register from [4:2]
    logic           nz_imm6;
    decoded_instr_t c_rec;
    logic           c_bad;

    assign c       = instr_i[15:0];
    assign is_rvc  = ENABLE_RVC && (c[1:0] != 2'b11);
    assign rs1_p   = {2'b01, c[9:7]};  // x8 to x15
    assign rs2_p   = {2'b01, c[4:2]};
    assign nz_imm6 = c[12] || (c[6:2] != 5'd0);

    // =========================================================================
    // Expansion, keyed on quadrant and funct3
    // =========================================================================
    always_comb begin
        c_rec = '0;
        c_bad = 1'b0;
        case ({c[1:0], c[15:13]})
            5'b00_000: begin  // C.ADDI4SPN
                c_rec.op  = OP_ADDI;
                c_rec.rd  = rs2_p;
                c_rec.rs1 = REG_SP;
                c_rec.imm = {22'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
                c_bad     = (c[12:5] == 8'd0);  // Also catches the all-zero word
            end
            5'b00_010, 5'b00_110: begin  // C.LW, C.SW
                c_rec.op  = c[15] ? OP_SW : OP_LW;
                c_rec.rd  = c[15] ? 5'd0 : rs2_p;
                c_rec.rs1 = rs1_p;
                c_rec.rs2 = c[15] ? rs2_p : 5'd0;
                c_rec.imm = {25'b0, c[5], c[12:10], c[6], 2'b00};
            end
            5'b01_000, 5'b01_010: begin  // C.NOP, C.ADDI, C.LI
                c_rec.op  = OP_ADDI;
                c_rec.rd  = c[11:7];
                c_rec.rs1 = c[14] ? 5'd0 : c[11:7];
                c_rec.imm = {{27{c[12]}}, c[6:2]};
            end
            5'b01_001, 5'b01_101: begin  // C.JAL, C.J
                c_rec.op  = OP_JAL;
                c_rec.rd  = c[15] ? 5'd0 : REG_RA;
                c_rec.imm = {{21{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11],
                             c[5:3], 1'b0};
            end
            5'b01_011: begin
                c_bad    = !nz_imm6;
                c_rec.rd = c[11:7];
                if (c[11:7] == REG_SP) begin  // C.ADDI16SP
                    c_rec.op  = OP_ADDI;
                    c_rec.rs1 = REG_SP;
                    c_rec.imm = {{23{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
                end else begin  // C.LUI
                    c_rec.op  = OP_LUI;
                    c_rec.imm = {{15{c[12]}}, c[6:2], 12'b0};
                end
            end
            5'b01_100: begin
                c_rec.rd  = rs1_p;
                c_rec.rs1 = rs1_p;
                case (c[11:10])
                    2'b00, 2'b01: begin  // C.SRLI, C.SRAI
                        c_rec.op  = c[10] ? OP_SRAI : OP_SRLI;
                        c_rec.imm = {27'b0, c[6:2]};
                        c_bad     = c[12];  // shamt[5] reserved on RV32
                    end
                    2'b10: begin  // C.ANDI
                        c_rec.op  = OP_ANDI;
                        c_rec.imm = {{27{c[12]}}, c[6:2]};
                    end
                    default: begin  // C.SUB, C.XOR, C.OR, C.AND
                        c_rec.rs2 = rs2_p;
                        c_bad     = c[12];  // RV64 word forms
                        case (c[6:5])
                            2'b00:   c_rec.op = OP_SUB;
                            2'b01:   c_rec.op = OP_XOR;
                            2'b10:   c_rec.op = OP_OR;
                            default: c_rec.op = OP_AND;
                        endcase
                    end
                endcase
            end
            5'b01_110, 5'b01_111: begin  // C.BEQZ, C.BNEZ
                c_rec.op  = c[13] ? OP_BNE : OP_BEQ;
                c_rec.rs1 = rs1_p;
                c_rec.imm = {{24{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
            end
            5'b10_000: begin  // C.SLLI
                c_rec.op  = OP_SLLI;
                c_rec.rd  = c[11:7];
                c_rec.rs1 = c[11:7];
                c_rec.imm = {27'b0, c[6:2]};
                c_bad     = c[12];
            end
            5'b10_010: begin  // C.LWSP
                c_rec.op  = OP_LW;
                c_rec.rd  = c[11:7];
                c_rec.rs1 = REG_SP;
                c_rec.imm = {24'b0, c[3:2], c[12], c[6:4], 2'b00};
                c_bad     = (c[11:7] == 5'd0);
            end
            5'b10_100: begin
                if (c[6:2] == 5'd0) begin  // C.JR, C.JALR
                    c_rec.op  = OP_JALR;
                    c_rec.rd  = c[12] ? REG_RA : 5'd0;
                    c_rec.rs1 = c[11:7];
                    c_bad     = (c[11:7] == 5'd0);  // Reserved form or C.EBREAK
                end else begin  // C.MV, C.ADD
                    c_rec.op  = OP_ADD;
                    c_rec.rd  = c[11:7];
                    c_rec.rs1 = c[12] ? c[11:7] : 5'd0;
                    c_rec.rs2 = c[6:2];
                end
            end
            5'b10_110: begin  // C.SWSP
                c_rec.op  = OP_SW;
                c_rec.rs1 = REG_SP;
                c_rec.rs2 = c[6:2];
                c_rec.imm = {24'b0, c[8:7], c[12:9], 2'b00};
            end
            default: c_bad = 1'b1;
        endcase

        // Every expansion reads a register except the upper and jump forms
        c_rec.load_rs = (c_rec.op != OP_LUI) && (c_rec.op != OP_JAL);
        if (c_bad) begin
            c_rec = '0;
        end
    end

    always_comb begin
        if (is_rvc) begin
            instr_o   = c_rec;
            illegal_o = c_bad;
        end else begin
            instr_o   = base_instr_i;  // 32-bit word, base result stands
            illegal_o = base_illegal_i;
        end
    end

endmodule

`default_nettype wire

// File: src/decode_out_reg.sv
// Decoder output register
`default_nettype none

module decode_out_reg (
    input  wire                                clk_i,
    input  wire                                rst_i,
    input  wire                                stb_i,
    input  wire rv_decode_pkg::decoded_instr_t instr_i,
    input  wire                                illegal_i,
    output rv_decode_pkg::decoded_instr_t      instr_o,
    output logic                               ack_o,
    output logic                               err_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_o <= '0;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
        end else begin
            ack_o <= stb_i && !illegal_i;  // One-cycle pulses
            err_o <= stb_i && illegal_i;
            if (stb_i) begin
                instr_o <= instr_i;  // Illegal record arrives zeroed
            end
        end
    end

endmodule

`default_nettype wire

// File: src/instr_decoder_top.sv
// Instruction decoder top level
`default_nettype none

module instr_decoder_top #(
    parameter bit ENABLE_RVC = 1'b1
) (
    input  wire                           clk_i,
    input  wire                           rst_i,
    input  wire                           stb_i,
    input  wire [rv_decode_pkg::XLEN-1:0] instr_i,
    output rv_decode_pkg::decoded_instr_t instr_o,
    output logic                          ack_o,
    output logic                          err_o
);

    import rv_decode_pkg::*;

    decoded_instr_t base_instr;
    logic           base_illegal;
    decoded_instr_t dec_instr;   // After compressed expansion
    logic           dec_illegal;

    rv32i_decoder u_base (
        .instr_i   (instr_i),
        .instr_o   (base_instr),
        .illegal_o (base_illegal)
    );

    rvc_decoder #(
        .ENABLE_RVC (ENABLE_RVC)
    ) u_rvc (
        .instr_i        (instr_i),
        .base_instr_i   (base_instr),
        .base_illegal_i (base_illegal),
        .instr_o        (dec_instr),
        .illegal_o      (dec_illegal)
    );

    decode_out_reg u_out (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stb_i     (stb_i),
        .instr_i   (dec_instr),
        .illegal_i (dec_illegal),
        .instr_o   (instr_o),
        .ack_o     (ack_o),
        .err_o     (err_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_instr_decoder.sv
// Instruction decoder testbench
`default_nettype none

module tb_instr_decoder;

    import rv_decode_pkg::*;

    localparam int MAX_VEC   = 64;
    localparam int VEC_WORDS = 8;      // instr, err, op, rd, rs1, rs2, imm, load_rs
    localparam logic [31:0] SEED = 32'd73018;

    logic            clk;
    logic            rst;
    logic            stb;
    logic [XLEN-1:0] instr;
    decoded_instr_t  dec;
    logic            ack;
    logic            err;

    logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS];  // Word 0 holds the vector count
    int          nvec;
    int          limit = 1000;
    int          cycle_cnt = 0;
    int          done_cnt = 0;
    int          drv_idx = 0;

    // Record that instr_o must show
    logic [31:0] exp_op;
    logic [31:0] exp_rd;
    logic [31:0] exp_rs1;
    logic [31:0] exp_rs2;
    logic [31:0] exp_imm;
    logic [31:0] exp_ld;

    instr_decoder_top #(
        .ENABLE_RVC (1'b1)
    ) dut0 (
        .clk_i   (clk),
        .rst_i   (rst),
        .stb_i   (stb),
        .instr_i (instr),
        .instr_o (dec),
        .ack_o   (ack),
        .err_o   (err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] vec_field(input int idx, input int field);
        return vec_mem[1 + idx * VEC_WORDS + field];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic compare_record(input string tag);
        check_value({tag, " op"}, exp_op, {26'b0, dec.op});
        check_value({tag, " rd"}, exp_rd, {27'b0, dec.rd});
        check_value({tag, " rs1"}, exp_rs1, {27'b0, dec.rs1});
        check_value({tag, " rs2"}, exp_rs2, {27'b0, dec.rs2});
        check_value({tag, " imm"}, exp_imm, dec.imm);
        check_value({tag, " load_rs"}, exp_ld, {31'b0, dec.load_rs});
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > limit) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                               cycle_cnt, done_cnt, nvec));
        end
    end

    // ========================================================================
    // Response checker on the falling edge
    // ========================================================================
    initial begin
        logic pend_valid;
        int   pend_idx;
        string tag;
        pend_valid = 1'b0;
        pend_idx   = 0;
        exp_op  = '0;
        exp_rd  = '0;
        exp_rs1 = '0;
        exp_rs2 = '0;
        exp_imm = '0;
        exp_ld  = '0;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (pend_valid) begin
                tag = $sformatf("vector %0d (%h)", pend_idx, vec_field(pend_idx, 0));
                if (ack && err) begin
                    fail_run({tag, " raised ack and err together"});
                end else if (!ack && !err) begin
                    fail_run({tag, " got no pulse one cycle after its strobe"});
                end
                check_value({tag, " err"}, vec_field(pend_idx, 1), {31'b0, err});
                exp_op  = vec_field(pend_idx, 2);
                exp_rd  = vec_field(pend_idx, 3);
                exp_rs1 = vec_field(pend_idx, 4);
                exp_rs2 = vec_field(pend_idx, 5);
                exp_imm = vec_field(pend_idx, 6);
                exp_ld  = vec_field(pend_idx, 7);
                compare_record(tag);
                done_cnt = done_cnt + 1;
            end else begin
                if (ack || err) begin
                    fail_run($sformatf("Pulse seen at cycle %0d without a strobe", cycle_cnt));
                end
                compare_record("idle hold");  // Also covers the reset value
            end
            pend_valid = stb;
            pend_idx   = drv_idx;
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        logic [31:0] rng;
        int          gap;
        rst   = 1'b1;
        stb   = 1'b0;
        instr = '0;
        rng   = SEED;
        $readmemh("tests/decoder_input.txt", vec_mem);
        nvec  = int'(vec_mem[0]);
        limit = nvec * 4 + 20;
        if (nvec <= 0 || nvec > MAX_VEC) begin
            fail_run("Vector file is empty or holds too many vectors");
        end

        repeat (4) @(posedge clk);
        #2 rst = 1'b0;

        for (int i = 0; i < nvec; i++) begin
            rng = xorshift32(rng);
            gap = int'(rng % 3);  // Zero gap gives back-to-back strobes
            repeat (gap) begin
                @(posedge clk);
                #2 stb = 1'b0;
            end
            @(posedge clk);
            #2;
            stb     = 1'b1;
            instr   = vec_field(i, 0);
            drv_idx = i;
        end
        @(posedge clk);
        #2 stb = 1'b0;

        wait (done_cnt == nvec);
        repeat (3) @(negedge clk);  // Idle cycles must hold the last record
        #1;
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/decoder_input.txt
// First word is the vector count, then one vector per line:
// instr err(1=error) op rd rs1 rs2 imm load_rs
32
fff10093 0 0f 01 02 00 ffffffff 1
005201b3 0 18 03 04 05 00000000 1
405201b3 0 19 03 04 05 00000000 1
4083d333 0 1f 06 07 08 00000000 1
0085a503 0 09 0a 0b 00 00000008 1
ffc14083 0 0a 01 02 00 fffffffc 1
00532623 0 0e 00 06 05 0000000c 1
fe110fa3 0 0c 00 02 01 ffffffff 1
00208863 0 01 00 01 02 00000010 1
fe419ce3 0 02 00 03 04 fffffff8 1
123452b7 0 22 05 00 00 12345000 0
fffff097 0 23 01 00 00 fffff000 0
001000ef 0 24 01 00 00 00000800 0
00008067 0 25 00 01 00 00000000 1
0ff0000f 0 26 00 00 00 000000ff 1
40315093 0 17 01 02 00 00000003 1
01f21213 0 15 04 04 00 0000001f 1
023100b3 1 00 00 00 00 00000000 0
00000073 1 00 00 00 00 00000000 0
00002063 1 00 00 00 00 00000000 0
40001013 1 00 00 00 00 00000000 0
0000100f 1 00 00 00 00 00000000 0
00000000 1 00 00 00 00 00000000 0
00000040 0 0f 08 02 00 00000004 1
00004144 0 09 09 0a 00 00000004 1
0000c504 0 0e 00 0a 09 00000008 1
00000001 0 0f 00 00 00 00000000 1
000010fd 0 0f 01 01 00 ffffffff 1
0000428d 0 0f 05 00 00 00000003 1
00006185 0 22 03 00 00 00001000 0
00006141 0 0f 02 02 00 00000010 1
00008009 0 16 08 08 00 00000002 1
000098f9 0 14 09 09 00 fffffffe 1
00008c05 0 19 08 08 09 00000000 1
00008d6d 0 21 0a 0a 0b 00000000 1
0000a021 0 24 00 00 00 00000008 0
00003ffd 0 24 01 00 00 fffffffe 0
0000c011 0 01 00 08 00 00000004 1
0000fcfd 0 02 00 09 00 fffffffe 1
00000292 0 15 05 05 00 00000004 1
000040a2 0 09 01 02 00 00000008 1
00008082 0 25 00 01 00 00000000 1
00009282 0 25 01 05 00 00000000 1
00008192 0 18 03 00 04 00000000 1
00009192 0 18 03 03 04 00000000 1
0000c21a 0 0e 00 02 06 00000004 1
00009002 1 00 00 00 00 00000000 0
00006101 1 00 00 00 00 00000000 0
00009c05 1 00 00 00 00 00000000 0
ffffffff 1 00 00 00 00 00000000 0

// File: filelist.f
src/rv_decode_pkg.sv
src/rv_imm_gen.sv
src/rv32i_decoder.sv
src/rvc_decoder.sv
src/decode_out_reg.sv
src/instr_decoder_top.sv
tests/tb_instr_decoder.sv

// File: run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_instr_decoder -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
echo "Pass message not found"
exit 1
